/* compile.f */
+incdir+hdl
hdl/tcdm_ecc_pkg.sv
hdl/hsiao_ecc_enc.sv
hdl/hsiao_ecc_dec.sv
hdl/tcdm_ecc_enc.sv
hdl/tcdm_ecc_bank.sv
hdl/tcdm_ecc_scrub_fsm.sv
hdl/tcdm_ecc_scrub_timer.sv
hdl/tcdm_ecc_top.sv
tb/tcdm_ecc_checker.sv
tb/tcdm_ecc_tb.sv

/* hdl/hsiao_ecc_dec.sv */
// combinational Hsiao SEC-DED decoder, same matrix as hsiao_ecc_enc
// a flipped check bit counts as single error, data is left as is
`timescale 1ns/1ns

module hsiao_ecc_dec #(
  parameter  int unsigned DATA_W = 32,
  localparam int unsigned PROT_W = $clog2(DATA_W) + 2
) (
  input  logic [DATA_W-1:0] data_i,
  input  logic [PROT_W-1:0] ecc_i,
  output logic [DATA_W-1:0] data_o,
  output logic              single_err_o,
  output logic              multi_err_o
);

  logic [DATA_W-1:0][PROT_W-1:0] h_cols;
  logic [PROT_W-1:0]             syndrome;
  logic                          hit;

  for (genvar i = 0; i < DATA_W; i++) begin : gen_cols
    assign h_cols[i] = PROT_W'(tcdm_ecc_pkg::hsiao_col(PROT_W, i));
  end

  // stored check bits against recomputed ones
  always_comb begin
    syndrome = ecc_i;
    for (int i = 0; i < DATA_W; i++) begin
      syndrome = syndrome ^ (h_cols[i] & {PROT_W{data_i[i]}});
    end
  end

  // locate the failing bit
  always_comb begin
    data_o = data_i;
    // weight one points at a check bit
    hit = ($countones(syndrome) == 1);
    for (int i = 0; i < DATA_W; i++) begin
      if (syndrome == h_cols[i]) begin
        data_o[i] = ~data_i[i];
        hit = 1'b1;
      end
    end
  end

  // even weight or no matching column
  assign single_err_o = hit;
  assign multi_err_o  = (syndrome != '0) && !hit;

endmodule

/* hdl/hsiao_ecc_enc.sv */
// combinational Hsiao SEC-DED check-bit generator
// needs DATA_W odd-weight columns of PROT_W bits, true for DATA_W up to 64
`timescale 1ns/1ns

module hsiao_ecc_enc #(
  parameter  int unsigned DATA_W = 32,
  localparam int unsigned PROT_W = $clog2(DATA_W) + 2
) (
  input  logic [DATA_W-1:0] data_i,
  output logic [PROT_W-1:0] ecc_o
);

  // one matrix column per data bit
  logic [DATA_W-1:0][PROT_W-1:0] h_cols;

  for (genvar i = 0; i < DATA_W; i++) begin : gen_cols
    assign h_cols[i] = PROT_W'(tcdm_ecc_pkg::hsiao_col(PROT_W, i));
  end

  // each set data bit toggles the check bits of its column
  always_comb begin
    ecc_o = '0;
    for (int i = 0; i < DATA_W; i++) begin
      ecc_o = ecc_o ^ (h_cols[i] & {PROT_W{data_i[i]}});
    end
  end

endmodule

/* hdl/tcdm_ecc_bank.sv */
// one bank of codewords; partial writes keep the initiator's check bits,
// so a stored word is only consistent when all byte enables were set
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_bank (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  tcdm_ecc_pkg::tcdm_ecc_req_t ecc_req_i,
  input  tcdm_ecc_pkg::tcdm_inj_t     inj_i,
  input  logic                        scrub_busy_i,
  input  logic                        scrub_wr_i,
  input  logic [`TCDM_AW-1:0]         scrub_addr_i,
  input  tcdm_ecc_pkg::tcdm_word_t    scrub_word_i,
  output logic                        gnt_o,
  output tcdm_ecc_pkg::tcdm_ecc_rsp_t ecc_rsp_o
);

  localparam int unsigned NB = `TCDM_DW / 8;

  tcdm_ecc_pkg::tcdm_word_t mem [`TCDM_DEPTH];
  tcdm_ecc_pkg::tcdm_word_t wr_word;
  tcdm_ecc_pkg::tcdm_word_t rd_word_q;

  logic [`TCDM_META_W-1:0] meta_fix;
  logic [`TCDM_AW-1:0]     addr_fix;
  logic                    wen_fix;
  logic [NB-1:0]           be_fix;
  logic                    meta_bad;
  logic                    port_acc;
  logic                    port_wr;
  logic                    port_rd;
  logic                    scrub_rd;
  logic [`TCDM_AW-1:0]     rd_addr;
  logic                    r_valid_q;
  logic                    r_opc_q;

  // metadata check, injected flips land on the incoming check bits
  hsiao_ecc_dec #(
    .DATA_W ( `TCDM_META_W )
  ) i_meta_dec (
    .data_i       ( {ecc_req_i.addr, ecc_req_i.wen, ecc_req_i.be} ),
    .ecc_i        ( ecc_req_i.meta_ecc ^ inj_i.meta_mask           ),
    .data_o       ( meta_fix                                       ),
    .single_err_o (                                                ),
    .multi_err_o  ( meta_bad                                       )
  );

  assign {addr_fix, wen_fix, be_fix} = meta_fix;

  // scrubber owns the bank while busy
  assign gnt_o    = ~scrub_busy_i;
  assign port_acc = ecc_req_i.req & gnt_o;
  assign port_wr  = port_acc & ~wen_fix & ~meta_bad;
  assign port_rd  = port_acc & wen_fix & ~meta_bad;
  assign scrub_rd = scrub_busy_i & ~scrub_wr_i;
  assign rd_addr  = scrub_busy_i ? scrub_addr_i : addr_fix;

  // data_mask flips stored bits, port writes only
  assign wr_word = {ecc_req_i.data, ecc_req_i.data_ecc} ^ inj_i.data_mask;

  // byte-merged port write, scrub write-back takes the whole word
  always_ff @(posedge clk_i) begin
    if (scrub_wr_i) begin
      mem[scrub_addr_i] <= scrub_word_i;
    end else if (port_wr) begin
      for (int b = 0; b < NB; b++) begin
        if (be_fix[b]) begin
          mem[addr_fix].data[b*8 +: 8] <= wr_word.data[b*8 +: 8];
        end
      end
      mem[addr_fix].data_ecc <= wr_word.data_ecc;
    end
  end

  // registered read; writes and dropped requests return zero
  always_ff @(posedge clk_i) begin
    if (port_rd || scrub_rd) begin
      rd_word_q <= mem[rd_addr];
    end else if (port_acc) begin
      rd_word_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r_valid_q <= 1'b0;
      r_opc_q   <= 1'b0;
    end else begin
      r_valid_q <= port_acc;
      r_opc_q   <= port_acc & meta_bad;
    end
  end

  always_comb begin
    ecc_rsp_o.r_valid    = r_valid_q;
    ecc_rsp_o.r_data     = rd_word_q.data;
    ecc_rsp_o.r_data_ecc = rd_word_q.data_ecc;
    ecc_rsp_o.r_opc      = r_opc_q;
  end

endmodule

/* hdl/tcdm_ecc_config.svh */
// fixed sizes of the ECC TCDM path; check-bit counts must equal $clog2(width)+2
// TCDM_DEPTH must not exceed 2**TCDM_AW
`ifndef TCDM_ECC_CONFIG_SVH
`define TCDM_ECC_CONFIG_SVH

// data word and its protected chunks
`define TCDM_DW 64
`define TCDM_CHUNK 32
`define TCDM_N_CHUNK 2
`define TCDM_EW_DW 7

// bank geometry
`define TCDM_AW 4
`define TCDM_DEPTH 16

// addr + wen + be, with its own check bits
`define TCDM_META_W 13
`define TCDM_EW_META 6

// cycles between two scrub ticks
`define TCDM_SCRUB_INTERVAL 20

`endif

/* hdl/tcdm_ecc_enc.sv */
// initiator-side ECC: check bits per data chunk and for addr/wen/be,
// correction of returned data; purely combinational
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_enc (
  input  tcdm_ecc_pkg::tcdm_req_t     req_i,
  output tcdm_ecc_pkg::tcdm_ecc_req_t ecc_req_o,
  input  tcdm_ecc_pkg::tcdm_ecc_rsp_t ecc_rsp_i,
  output tcdm_ecc_pkg::tcdm_rsp_t     rsp_o
);

  localparam int unsigned N_CHUNK = `TCDM_N_CHUNK;
  localparam int unsigned CHUNK   = `TCDM_CHUNK;
  localparam int unsigned EW_DW   = `TCDM_EW_DW;
  localparam int unsigned META_W  = `TCDM_META_W;

  // write side
  logic [N_CHUNK-1:0][CHUNK-1:0] wdata;
  logic [N_CHUNK-1:0][EW_DW-1:0] wdata_ecc;
  logic [META_W-1:0]             meta;
  logic [`TCDM_EW_META-1:0]      meta_ecc;

  // read side
  logic [N_CHUNK-1:0][CHUNK-1:0] rdata;
  logic [N_CHUNK-1:0][EW_DW-1:0] rdata_ecc;
  logic [N_CHUNK-1:0][CHUNK-1:0] rdata_fix;
  logic [N_CHUNK-1:0]            single_err;
  logic [N_CHUNK-1:0]            multi_err;

  // chunk 0 is the low half of the word
  assign wdata     = req_i.data;
  assign rdata     = ecc_rsp_i.r_data;
  assign rdata_ecc = ecc_rsp_i.r_data_ecc;

  // same field order as the bank checks
  assign meta = {req_i.addr, req_i.wen, req_i.be};

  for (genvar ii = 0; ii < N_CHUNK; ii++) begin : gen_chunk
    // write data check bits
    hsiao_ecc_enc #(
      .DATA_W ( CHUNK )
    ) i_data_enc (
      .data_i ( wdata[ii]     ),
      .ecc_o  ( wdata_ecc[ii] )
    );

    // read data correction
    hsiao_ecc_dec #(
      .DATA_W ( CHUNK )
    ) i_data_dec (
      .data_i       ( rdata[ii]      ),
      .ecc_i        ( rdata_ecc[ii]  ),
      .data_o       ( rdata_fix[ii]  ),
      .single_err_o ( single_err[ii] ),
      .multi_err_o  ( multi_err[ii]  )
    );
  end

  // metadata check bits
  hsiao_ecc_enc #(
    .DATA_W ( META_W )
  ) i_meta_enc (
    .data_i ( meta     ),
    .ecc_o  ( meta_ecc )
  );

  // request fields pass through, check bits appended
  always_comb begin
    ecc_req_o.req      = req_i.req;
    ecc_req_o.addr     = req_i.addr;
    ecc_req_o.wen      = req_i.wen;
    ecc_req_o.be       = req_i.be;
    ecc_req_o.data     = req_i.data;
    ecc_req_o.data_ecc = wdata_ecc;
    ecc_req_o.meta_ecc = meta_ecc;
  end

  // write responses carry zero data and zero ecc, so flags stay clear
  always_comb begin
    rsp_o.r_valid      = ecc_rsp_i.r_valid;
    rsp_o.r_data       = rdata_fix;
    rsp_o.r_opc        = ecc_rsp_i.r_opc;
    rsp_o.r_single_err = single_err;
    rsp_o.r_multi_err  = multi_err;
  end

endmodule

/* hdl/tcdm_ecc_pkg.sv */
// types of the ECC TCDM path, sized by the config header
// hsiao_col gives the shared parity-check matrix of both Hsiao blocks
`include "tcdm_ecc_config.svh"

package tcdm_ecc_pkg;

  // plain request, wen high means read
  typedef struct packed {
    logic                  req;
    logic [`TCDM_AW-1:0]   addr;
    logic                  wen;
    logic [`TCDM_DW/8-1:0] be;
    logic [`TCDM_DW-1:0]   data;
  } tcdm_req_t;

  // request with data and metadata check bits attached
  typedef struct packed {
    logic                                      req;
    logic [`TCDM_AW-1:0]                       addr;
    logic                                      wen;
    logic [`TCDM_DW/8-1:0]                     be;
    logic [`TCDM_DW-1:0]                       data;
    logic [`TCDM_N_CHUNK-1:0][`TCDM_EW_DW-1:0] data_ecc;
    logic [`TCDM_EW_META-1:0]                  meta_ecc;
  } tcdm_ecc_req_t;

  // bank response, r_opc flags a dropped request
  typedef struct packed {
    logic                                      r_valid;
    logic [`TCDM_DW-1:0]                       r_data;
    logic [`TCDM_N_CHUNK-1:0][`TCDM_EW_DW-1:0] r_data_ecc;
    logic                                      r_opc;
  } tcdm_ecc_rsp_t;

  // corrected response with per-chunk error flags
  typedef struct packed {
    logic                     r_valid;
    logic [`TCDM_DW-1:0]      r_data;
    logic                     r_opc;
    logic [`TCDM_N_CHUNK-1:0] r_single_err;
    logic [`TCDM_N_CHUNK-1:0] r_multi_err;
  } tcdm_rsp_t;

  // one stored codeword
  typedef struct packed {
    logic [`TCDM_DW-1:0]                       data;
    logic [`TCDM_N_CHUNK-1:0][`TCDM_EW_DW-1:0] data_ecc;
  } tcdm_word_t;

  // fault injection masks
  typedef struct packed {
    logic [$bits(tcdm_word_t)-1:0] data_mask;
    logic [`TCDM_EW_META-1:0]      meta_mask;
  } tcdm_inj_t;

  typedef enum logic [1:0] {
    SCRUB_IDLE,
    SCRUB_READ,
    SCRUB_CHECK,
    SCRUB_WRITE
  } scrub_state_e;

  // column idx of the Hsiao matrix: idx-th odd-weight code of weight >= 3
  function automatic logic [31:0] hsiao_col(input int unsigned prot_w,
                                            input int unsigned idx);
    int unsigned cnt;
    logic [31:0] cand;
    logic [31:0] col;
    cnt = 0;
    col = '0;
    for (int unsigned v = 0; v < (32'd1 << prot_w); v++) begin
      cand = 32'(v);
      if ($countones(cand) >= 3 && $countones(cand) % 2 == 1) begin
        if (cnt == idx) begin
          col = cand;
        end
        cnt++;
      end
    end
    return col;
  endfunction

endpackage

/* hdl/tcdm_ecc_scrub_fsm.sv */
// scrubs one word per tick; a tick waits while the port is accepting,
// write-back only when some chunk has a single error and none a multi error
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_scrub_fsm (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        tick_i,
  input  logic                        port_req_i,
  input  logic [`TCDM_AW-1:0]         addr_i,
  input  tcdm_ecc_pkg::tcdm_ecc_rsp_t rsp_i,
  output logic                        busy_o,
  output logic                        wr_o,
  output logic [`TCDM_AW-1:0]         addr_o,
  output tcdm_ecc_pkg::tcdm_word_t    word_o,
  output logic                        done_o,
  output logic                        fix_o
);

  localparam int unsigned N_CHUNK = `TCDM_N_CHUNK;
  localparam int unsigned CHUNK   = `TCDM_CHUNK;

  tcdm_ecc_pkg::scrub_state_e state_q;
  tcdm_ecc_pkg::scrub_state_e state_d;

  logic                                 pending_q;
  logic                                 start;
  logic                                 need_fix;
  logic [N_CHUNK-1:0][CHUNK-1:0]        rdata;
  logic [N_CHUNK-1:0][CHUNK-1:0]        fix_data;
  logic [N_CHUNK-1:0][`TCDM_EW_DW-1:0]  fix_ecc;
  logic [N_CHUNK-1:0]                   single_err;
  logic [N_CHUNK-1:0]                   multi_err;

  assign rdata = rsp_i.r_data;

  for (genvar ii = 0; ii < N_CHUNK; ii++) begin : gen_chunk
    hsiao_ecc_dec #(
      .DATA_W ( CHUNK )
    ) i_dec (
      .data_i       ( rdata[ii]            ),
      .ecc_i        ( rsp_i.r_data_ecc[ii] ),
      .data_o       ( fix_data[ii]         ),
      .single_err_o ( single_err[ii]       ),
      .multi_err_o  ( multi_err[ii]        )
    );

    // fresh check bits for the corrected chunk
    hsiao_ecc_enc #(
      .DATA_W ( CHUNK )
    ) i_enc (
      .data_i ( fix_data[ii] ),
      .ecc_o  ( fix_ecc[ii]  )
    );
  end

  // only meaningful in idle, where gnt is high
  assign start    = (tick_i | pending_q) & ~port_req_i;
  assign need_fix = (|single_err) & ~(|multi_err);

  always_comb begin
    state_d = state_q;
    case (state_q)
      tcdm_ecc_pkg::SCRUB_IDLE: begin
        if (start) begin
          state_d = tcdm_ecc_pkg::SCRUB_READ;
        end
      end
      tcdm_ecc_pkg::SCRUB_READ:  state_d = tcdm_ecc_pkg::SCRUB_CHECK;
      tcdm_ecc_pkg::SCRUB_CHECK: begin
        if (need_fix) begin
          state_d = tcdm_ecc_pkg::SCRUB_WRITE;
        end else begin
          state_d = tcdm_ecc_pkg::SCRUB_IDLE;
        end
      end
      default: state_d = tcdm_ecc_pkg::SCRUB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= tcdm_ecc_pkg::SCRUB_IDLE;
      pending_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      // held until a pass starts
      pending_q <= (tick_i | pending_q) &
                   ~(state_q == tcdm_ecc_pkg::SCRUB_IDLE && !port_req_i);
    end
  end

  // address frozen for the whole pass, word taken in check
  always_ff @(posedge clk_i) begin
    if (state_q == tcdm_ecc_pkg::SCRUB_IDLE && start) begin
      addr_o <= addr_i;
    end
    if (state_q == tcdm_ecc_pkg::SCRUB_CHECK) begin
      word_o <= {fix_data, fix_ecc};
    end
  end

  assign busy_o = (state_q != tcdm_ecc_pkg::SCRUB_IDLE);
  assign wr_o   = (state_q == tcdm_ecc_pkg::SCRUB_WRITE);
  assign fix_o  = (state_q == tcdm_ecc_pkg::SCRUB_WRITE);
  // last busy cycle of a pass
  assign done_o = busy_o && (state_d == tcdm_ecc_pkg::SCRUB_IDLE);

endmodule

/* hdl/tcdm_ecc_scrub_timer.sv */
// scrub tick every TCDM_SCRUB_INTERVAL cycles, first one that long after reset
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_scrub_timer (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                done_i,
  output logic                tick_o,
  output logic [`TCDM_AW-1:0] addr_o
);

  localparam int unsigned CNT_W = $clog2(`TCDM_SCRUB_INTERVAL + 1);

  logic [CNT_W-1:0] cnt_q;

  // counts interval..1, zero only right after reset
  assign tick_o = (cnt_q == CNT_W'(1));

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      addr_o <= '0;
    end else begin
      // reload on tick
      if (cnt_q <= CNT_W'(1)) begin
        cnt_q <= CNT_W'(`TCDM_SCRUB_INTERVAL);
      end else begin
        cnt_q <= cnt_q - CNT_W'(1);
      end
      // next word once a pass is over
      if (done_i) begin
        addr_o <= (addr_o == `TCDM_AW'(`TCDM_DEPTH - 1)) ? '0 : addr_o + `TCDM_AW'(1);
      end
    end
  end

endmodule

/* hdl/tcdm_ecc_top.sv */
// ECC-protected TCDM path with background scrubber
// gnt_o drops only while the scrubber owns the bank
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  tcdm_ecc_pkg::tcdm_req_t req_i,
  output logic                    gnt_o,
  input  tcdm_ecc_pkg::tcdm_inj_t inj_i,
  output tcdm_ecc_pkg::tcdm_rsp_t rsp_o,
  output logic                    scrub_fix_o
);

  tcdm_ecc_pkg::tcdm_ecc_req_t ecc_req;
  tcdm_ecc_pkg::tcdm_ecc_rsp_t ecc_rsp;
  tcdm_ecc_pkg::tcdm_word_t    scrub_word;

  logic                scrub_tick;
  logic                scrub_done;
  logic                scrub_busy;
  logic                scrub_wr;
  logic [`TCDM_AW-1:0] timer_addr;
  logic [`TCDM_AW-1:0] scrub_addr;

  // request encode and response correction
  tcdm_ecc_enc i_enc (
    .req_i     ( req_i   ),
    .ecc_req_o ( ecc_req ),
    .ecc_rsp_i ( ecc_rsp ),
    .rsp_o     ( rsp_o   )
  );

  tcdm_ecc_bank i_bank (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .ecc_req_i    ( ecc_req    ),
    .inj_i        ( inj_i      ),
    .scrub_busy_i ( scrub_busy ),
    .scrub_wr_i   ( scrub_wr   ),
    .scrub_addr_i ( scrub_addr ),
    .scrub_word_i ( scrub_word ),
    .gnt_o        ( gnt_o      ),
    .ecc_rsp_o    ( ecc_rsp    )
  );

  // port_req is the plain req, gnt is high whenever the fsm is idle
  tcdm_ecc_scrub_fsm i_scrub_fsm (
    .clk_i      ( clk_i       ),
    .rst_n_i    ( rst_n_i     ),
    .tick_i     ( scrub_tick  ),
    .port_req_i ( req_i.req   ),
    .addr_i     ( timer_addr  ),
    .rsp_i      ( ecc_rsp     ),
    .busy_o     ( scrub_busy  ),
    .wr_o       ( scrub_wr    ),
    .addr_o     ( scrub_addr  ),
    .word_o     ( scrub_word  ),
    .done_o     ( scrub_done  ),
    .fix_o      ( scrub_fix_o )
  );

  tcdm_ecc_scrub_timer i_scrub_timer (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .done_i  ( scrub_done ),
    .tick_o  ( scrub_tick ),
    .addr_o  ( timer_addr )
  );

endmodule

/* tb/tcdm_ecc_checker.sv */
// compares each rsp against a data model and per-test expected flags
// expectations are taken when req and gnt meet, responses assumed in order
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_checker (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  tcdm_ecc_pkg::tcdm_req_t    req_i,
  input  logic                       gnt_i,
  input  tcdm_ecc_pkg::tcdm_rsp_t    rsp_i,
  input  logic                       scrub_fix_i,
  input  logic [8*12-1:0]            name_i,
  input  logic                       cmp_data_i,
  input  logic [`TCDM_N_CHUNK-1:0]   exp_single_i,
  input  logic [`TCDM_N_CHUNK-1:0]   exp_multi_i,
  input  logic                       exp_opc_i,
  input  logic                       report_i,
  output int                         tests_o,
  output int                         errors_o
);

  typedef struct packed {
    logic [8*12-1:0]           name;
    logic [`TCDM_AW-1:0]       addr;
    logic                      cmp_data;
    logic [`TCDM_DW-1:0]       data;
    logic [2*`TCDM_N_CHUNK:0]  flags;
  } exp_t;

  // last data written per address
  logic [`TCDM_DW-1:0] model [`TCDM_DEPTH];
  exp_t                pend_q [$];
  int                  fixes;
  logic                reported = 1'b0;

  // expected response for an accepted request
  task automatic record_req();
    exp_t e;
    e.name     = name_i;
    e.addr     = req_i.addr;
    e.cmp_data = cmp_data_i;
    // write responses carry zero data
    e.data     = req_i.wen ? model[req_i.addr] : '0;
    e.flags    = {exp_opc_i, exp_single_i, exp_multi_i};
    // dropped writes leave the model alone
    if (!req_i.wen && !exp_opc_i) begin
      model[req_i.addr] = req_i.data;
    end
    pend_q.push_back(e);
  endtask

  task automatic check_rsp();
    exp_t                     e;
    logic [2*`TCDM_N_CHUNK:0] act_flags;
    int                       bad;
    act_flags = {rsp_i.r_opc, rsp_i.r_single_err, rsp_i.r_multi_err};
    bad       = 0;
    if (pend_q.size() == 0) begin
      $display("error: response arrived with no accepted request");
      errors_o++;
    end else begin
      e = pend_q.pop_front();
      tests_o++;
      if (e.cmp_data && rsp_i.r_data !== e.data) begin
        $display("MISMATCH %s addr %0d data: expected %h, actual %h",
                 e.name, e.addr, e.data, rsp_i.r_data);
        bad++;
      end
      // opc, single flags, multi flags
      if (act_flags !== e.flags) begin
        $display("MISMATCH %s addr %0d flags: expected %b, actual %b",
                 e.name, e.addr, e.flags, act_flags);
        bad++;
      end
      if (bad == 0) begin
        $display("ok       %s addr %0d", e.name, e.addr);
      end
      errors_o += bad;
    end
  endtask

  // sampled away from the rising edge, response before new request
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (scrub_fix_i) begin
        fixes++;
      end
      if (rsp_i.r_valid) begin
        check_rsp();
      end
      if (req_i.req && gnt_i) begin
        record_req();
      end
      if (report_i && !reported) begin
        if (pend_q.size() != 0) begin
          $display("error: %0d responses never arrived", pend_q.size());
          errors_o++;
        end
        if (fixes == 0) begin
          $display("error: scrubber never wrote back a corrected word");
          errors_o++;
        end
        $display("summary: %0d tests checked, %0d errors, %0d scrub fixes",
                 tests_o, errors_o, fixes);
        reported = 1'b1;
      end
    end
  end

endmodule

/* tb/tcdm_ecc_tb.sv */
// table-driven testbench, requests issued back to back so the scrubber
// only runs in the idle gaps that the table asks for
`timescale 1ns/1ns
`include "tcdm_ecc_config.svh"

module tcdm_ecc_tb;

  localparam int N_ENTRIES = 50;
  // per entry one access plus up to an interval of stall, then a full scrub sweep
  localparam int TIMEOUT_CYCLES = N_ENTRIES * (2 + `TCDM_SCRUB_INTERVAL) +
                                  `TCDM_DEPTH * `TCDM_SCRUB_INTERVAL;
  localparam int MASK_W = $bits(tcdm_ecc_pkg::tcdm_word_t);

  typedef struct packed {
    logic [8*12-1:0]          name;
    logic [9:0]               idle;
    logic                     wr;
    logic [`TCDM_AW-1:0]      addr;
    logic [`TCDM_DW-1:0]      data;
    tcdm_ecc_pkg::tcdm_inj_t  inj;
    logic                     cmp_data;
    logic [`TCDM_N_CHUNK-1:0] exp_single;
    logic [`TCDM_N_CHUNK-1:0] exp_multi;
    logic                     exp_opc;
  } entry_t;

  logic                     clk;
  logic                     rst_n;
  tcdm_ecc_pkg::tcdm_req_t  req;
  logic                     gnt;
  tcdm_ecc_pkg::tcdm_inj_t  inj;
  tcdm_ecc_pkg::tcdm_rsp_t  rsp;
  logic                     scrub_fix;
  logic [8*12-1:0]          exp_name;
  logic                     exp_cmp;
  logic [`TCDM_N_CHUNK-1:0] exp_single;
  logic [`TCDM_N_CHUNK-1:0] exp_multi;
  logic                     exp_opc;
  logic                     report;
  int                       tests;
  int                       errors;
  int                       cycle_cnt;
  int                       seed;
  int                       n_tbl;
  entry_t                   tbl [N_ENTRIES];
  logic [`TCDM_DW-1:0]      fill_data [`TCDM_DEPTH];

  always #50 clk = ~clk;

  tcdm_ecc_top i_tcdm_ecc_top (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .req_i       ( req       ),
    .gnt_o       ( gnt       ),
    .inj_i       ( inj       ),
    .rsp_o       ( rsp       ),
    .scrub_fix_o ( scrub_fix )
  );

  tcdm_ecc_checker i_tcdm_ecc_checker (
    .clk_i        ( clk        ),
    .rst_n_i      ( rst_n      ),
    .req_i        ( req        ),
    .gnt_i        ( gnt        ),
    .rsp_i        ( rsp        ),
    .scrub_fix_i  ( scrub_fix  ),
    .name_i       ( exp_name   ),
    .cmp_data_i   ( exp_cmp    ),
    .exp_single_i ( exp_single ),
    .exp_multi_i  ( exp_multi  ),
    .exp_opc_i    ( exp_opc    ),
    .report_i     ( report     ),
    .tests_o      ( tests      ),
    .errors_o     ( errors     )
  );

  // codeword bit a, and b unless negative; data bit i sits at 14+i
  function automatic logic [MASK_W-1:0] flip_bits(input int a, input int b);
    logic [MASK_W-1:0] m;
    m    = '0;
    m[a] = 1'b1;
    if (b >= 0) begin
      m[b] = 1'b1;
    end
    return m;
  endfunction

  task automatic add_entry(input logic [8*12-1:0] name, input int idle, input logic wr,
                           input int addr, input logic [`TCDM_DW-1:0] data,
                           input logic [MASK_W-1:0] dmask,
                           input logic [`TCDM_EW_META-1:0] mmask, input logic cmp,
                           input logic [1:0] single, input logic [1:0] multi,
                           input logic opc);
    tbl[n_tbl] = {name, 10'(idle), wr, `TCDM_AW'(addr), data, dmask, mmask,
                  cmp, single, multi, opc};
    n_tbl++;
  endtask

  task automatic build_table();
    seed = 95;
    for (int a = 0; a < `TCDM_DEPTH; a++) begin
      fill_data[a] = {$random(seed), $random(seed)};
      add_entry("fill_wr", 0, 1, a, fill_data[a], '0, '0, 1, 2'b00, 2'b00, 0);
    end
    for (int a = 0; a < `TCDM_DEPTH; a++) begin
      add_entry("fill_rd", 0, 0, a, '0, '0, '0, 1, 2'b00, 2'b00, 0);
    end
    // single flips: chunk 0 data, chunk 1 data, chunk 1 check bit
    add_entry("sec_c0_wr", 0, 1, 1, 64'h0123_4567_89ab_cdef, flip_bits(19, -1), '0, 1, 0, 0, 0);
    add_entry("sec_c0_rd", 0, 0, 1, '0, '0, '0, 1, 2'b01, 2'b00, 0);
    add_entry("sec_c1_wr", 0, 1, 2, 64'hfedc_ba98_7654_3210, flip_bits(54, -1), '0, 1, 0, 0, 0);
    add_entry("sec_c1_rd", 0, 0, 2, '0, '0, '0, 1, 2'b10, 2'b00, 0);
    add_entry("sec_ecc_wr", 0, 1, 3, 64'h0f0f_f0f0_a5a5_5a5a, flip_bits(10, -1), '0, 1, 0, 0, 0);
    add_entry("sec_ecc_rd", 0, 0, 3, '0, '0, '0, 1, 2'b10, 2'b00, 0);
    // double flips, data not compared
    add_entry("ded_c0_wr", 0, 1, 6, 64'h1357_9bdf_2468_ace0, flip_bits(14, 15), '0, 1, 0, 0, 0);
    add_entry("ded_c0_rd", 0, 0, 6, '0, '0, '0, 0, 2'b00, 2'b01, 0);
    add_entry("ded_c1_wr", 0, 1, 7, 64'h8000_0001_7fff_fffe, flip_bits(47, 74), '0, 1, 0, 0, 0);
    add_entry("ded_c1_rd", 0, 0, 7, '0, '0, '0, 0, 2'b00, 2'b10, 0);
    // metadata: one flip corrected, two flips drop the write
    add_entry("meta1_wr", 0, 1, 4, 64'h1111_2222_3333_4444, '0, 6'b000100, 1, 0, 0, 0);
    add_entry("meta1_rd", 0, 0, 4, '0, '0, '0, 1, 2'b00, 2'b00, 0);
    add_entry("meta2_wr", 0, 1, 5, 64'h5555_6666_7777_8888, '0, 6'b100001, 1, 0, 0, 1);
    add_entry("meta2_rd", 0, 0, 5, '0, '0, '0, 1, 2'b00, 2'b00, 0);
    // scrub repairs addr 8 during the long gap
    add_entry("scrub_wr", 0, 1, 8, 64'hcafe_0000_1234_5678, flip_bits(34, -1), '0, 1, 0, 0, 0);
    // both reads arrive in the check cycle of a repairing pass and wait for gnt
    add_entry("busy_rd_a", 14, 0, 9, '0, '0, '0, 1, 2'b00, 2'b00, 0);
    add_entry("busy_rd_b", 17, 0, 10, '0, '0, '0, 1, 2'b00, 2'b00, 0);
    add_entry("scrub_rd", `TCDM_DEPTH * `TCDM_SCRUB_INTERVAL + 20, 0, 8, '0, '0, '0,
              1, 2'b00, 2'b00, 0);
  endtask

  task automatic drive_entry(input entry_t e);
    req.req    <= 1'b1;
    req.addr   <= e.addr;
    // wen high means read
    req.wen    <= ~e.wr;
    req.be     <= '1;
    req.data   <= e.data;
    inj        <= e.inj;
    exp_name   <= e.name;
    exp_cmp    <= e.cmp_data;
    exp_single <= e.exp_single;
    exp_multi  <= e.exp_multi;
    exp_opc    <= e.exp_opc;
  endtask

  // gnt only moves on the rising edge, so the falling edge sees its next value
  task automatic wait_grant();
    @(negedge clk);
    while (!gnt) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    req        = '0;
    inj        = '0;
    exp_name   = '0;
    exp_cmp    = 1'b0;
    exp_single = '0;
    exp_multi  = '0;
    exp_opc    = 1'b0;
    report     = 1'b0;
    n_tbl      = 0;
    build_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < N_ENTRIES; i++) begin
      // idle gap lets the scrubber take the bank
      if (tbl[i].idle != 0) begin
        req.req <= 1'b0;
        inj     <= '0;
        repeat (tbl[i].idle) @(posedge clk);
      end
      drive_entry(tbl[i]);
      wait_grant();
    end
    req <= '0;
    inj <= '0;
    repeat (3) @(posedge clk);
    report <= 1'b1;
    repeat (2) @(posedge clk);
    if (errors == 0 && tests == N_ENTRIES) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

endmodule
